// ==== include/spi_host_consts.svh ====
`ifndef SPI_HOST_CONSTS_SVH
`define SPI_HOST_CONSTS_SVH

`define SPI_ADDR_CTRL     5'h00
`define SPI_ADDR_STATUS   5'h04
`define SPI_ADDR_RDATA    5'h08
`define SPI_ADDR_WDATA    5'h0c
`define SPI_ADDR_CMD      5'h10

`define SPI_CMD_DEPTH     8
`define SPI_DATA_DEPTH    8

`define SPI_CMD_HOLD_BIT  9
`define SPI_CMD_DIR_LSB   12
`define SPI_CTRL_EN_BIT   0
`define SPI_CTRL_CPHA_BIT 2
`define SPI_CTRL_CPOL_BIT 3
`define SPI_CTRL_DIV_LSB  16

`endif

// ==== design/spi_host_pkg.sv ====
`default_nettype none

package spi_host_pkg;

    typedef logic [31:0] word_t;     // bus and data word
    typedef logic [13:0] cmd_t;      // len 8:0, hold 9, dir 13:12
    typedef logic [8:0]  len_t;      // bytes minus one
    typedef logic [15:0] div_t;
    typedef logic [4:0]  wb_addr_t;  // byte address

    // direction codes as written into cmd bits 13:12
    typedef enum logic [1:0] {
        dir_dummy = 2'd0,
        dir_rx    = 2'd1,
        dir_tx    = 2'd2
    } xfer_dir_e;

    typedef enum logic [1:0] {
        seq_idle,
        seq_issue,
        seq_wait
    } seq_state_e;

    // lead: sck at cpol, waiting for leading edge
    // trail: sck active, waiting for trailing edge
    typedef enum logic [1:0] {
        sh_idle,
        sh_lead,
        sh_trail
    } shift_state_e;

endpackage

`default_nettype wire

// ==== design/spi_fifo_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface spi_fifo_if #(
    parameter int WIDTH = 32
);
    logic             push;
    logic [WIDTH-1:0] wdata;
    logic             full;
    logic             pop;
    logic [WIDTH-1:0] rdata;  // head word
    logic             empty;

    modport writer (output push, output wdata, input full, input empty);
    modport reader (output pop, input rdata, input empty, input full);

    // queue side of each port
    modport sink   (input push, input wdata, output full);
    modport source (input pop, output rdata, output empty);
endinterface

// sequencer to shifter, one byte per request
interface spi_byte_if import spi_host_pkg::*; ();
    logic      byte_req;
    xfer_dir_e byte_dir;
    logic      last_byte;
    logic      busy;
    logic      byte_done;

    modport master (output byte_req, output byte_dir, output last_byte,
                    input busy, input byte_done);
    modport slave  (input byte_req, input byte_dir, input last_byte,
                    output busy, output byte_done);
endinterface

`default_nettype wire

// ==== design/spi_word_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_word_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 8
) (
    input  wire         clk_i,
    input  wire         rst_i,
    spi_fifo_if.sink    wr,
    spi_fifo_if.source  rd
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;
    logic             do_push;
    logic             do_pop;

    assign wr.full  = (count == DEPTH);
    assign rd.empty = (count == '0);
    assign rd.rdata = mem[rd_ptr];  // fall-through head

    assign do_push = wr.push && !wr.full;
    assign do_pop  = rd.pop && !rd.empty;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= wr.wdata;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/spi_wb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_host_consts.svh"

module spi_wb_regs import spi_host_pkg::*; (
    input  wire         clk_i,
    input  wire         rst_i,

    input  wire         wb_cyc_i,
    input  wire         wb_stb_i,
    input  wire         wb_we_i,
    input  wire wb_addr_t wb_adr_i,
    input  wire word_t  wb_dat_i,
    output word_t       wb_dat_o,
    output logic        wb_ack_o,

    spi_fifo_if.writer  cmd_w,
    spi_fifo_if.writer  tx_w,
    spi_fifo_if.reader  rx_r,

    input  wire         seq_busy_i,
    output logic        cpol_o,
    output logic        cpha_o,
    output logic        en_o,
    output div_t        div_o
);
    logic  req;
    logic  wr_req;
    logic  rd_req;
    logic  en_q;
    logic  cpha_q;
    logic  cpol_q;
    div_t  div_q;
    word_t ctrl_rd;
    word_t status_rd;
    word_t rd_data;

    assign req    = wb_cyc_i && wb_stb_i && !wb_ack_o;  // one access per ack
    assign wr_req = req && wb_we_i;
    assign rd_req = req && !wb_we_i;

    assign cmd_w.push  = wr_req && (wb_adr_i == `SPI_ADDR_CMD);
    assign cmd_w.wdata = wb_dat_i[$bits(cmd_t)-1:0];
    assign tx_w.push   = wr_req && (wb_adr_i == `SPI_ADDR_WDATA);
    assign tx_w.wdata  = wb_dat_i;
    assign rx_r.pop    = rd_req && (wb_adr_i == `SPI_ADDR_RDATA);

    assign en_o   = en_q;
    assign cpha_o = cpha_q;
    assign cpol_o = cpol_q;
    assign div_o  = div_q;

    always_comb begin
        ctrl_rd                                   = '0;
        ctrl_rd[`SPI_CTRL_EN_BIT]                 = en_q;
        ctrl_rd[`SPI_CTRL_CPHA_BIT]               = cpha_q;
        ctrl_rd[`SPI_CTRL_CPOL_BIT]               = cpol_q;
        ctrl_rd[`SPI_CTRL_DIV_LSB +: $bits(div_t)] = div_q;
    end

    assign status_rd = {25'd0, seq_busy_i,
                        cmd_w.empty, cmd_w.full,
                        rx_r.empty, rx_r.full,
                        tx_w.empty, tx_w.full};

    always_comb begin
        case (wb_adr_i)
            `SPI_ADDR_CTRL:   rd_data = ctrl_rd;
            `SPI_ADDR_STATUS: rd_data = status_rd;
            `SPI_ADDR_RDATA:  rd_data = rx_r.empty ? '0 : rx_r.rdata;
            default:          rd_data = '0;  // write-only and unknown
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_ack_o <= 1'b0;
            wb_dat_o <= '0;
            en_q     <= 1'b0;
            cpha_q   <= 1'b0;
            cpol_q   <= 1'b0;
            div_q    <= '0;
        end else begin
            wb_ack_o <= req;
            if (rd_req) begin
                wb_dat_o <= rd_data;  // head captured as it pops
            end
            if (wr_req && (wb_adr_i == `SPI_ADDR_CTRL)) begin
                en_q   <= wb_dat_i[`SPI_CTRL_EN_BIT];
                cpha_q <= wb_dat_i[`SPI_CTRL_CPHA_BIT];
                cpol_q <= wb_dat_i[`SPI_CTRL_CPOL_BIT];
                div_q  <= wb_dat_i[`SPI_CTRL_DIV_LSB +: $bits(div_t)];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/spi_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_host_consts.svh"

module spi_sequencer import spi_host_pkg::*; (
    input  wire         clk_i,
    input  wire         rst_i,
    input  wire         en_i,
    spi_fifo_if.reader  cmd_r,
    spi_byte_if.master  link,
    output logic        spi_cs_o,
    output logic        busy_o
);
    seq_state_e state;
    cmd_t       head;
    xfer_dir_e  head_dir;
    xfer_dir_e  dir_q;
    logic       hold_q;
    len_t       bytes_left;
    logic       cs_q;
    logic       take;

    assign head = cmd_r.rdata;

    always_comb begin
        case (head[`SPI_CMD_DIR_LSB +: 2])
            2'b01:   head_dir = dir_rx;
            2'b10:   head_dir = dir_tx;
            default: head_dir = dir_dummy;  // code 3 too
        endcase
    end

    assign take      = (state == seq_idle) && en_i && !cmd_r.empty;
    assign cmd_r.pop = take;

    assign link.byte_req  = (state == seq_issue) && !link.busy;
    assign link.byte_dir  = dir_q;
    assign link.last_byte = (bytes_left == '0);

    assign spi_cs_o = cs_q;
    assign busy_o   = (state != seq_idle);

    // command fields, held for the whole command
    always_ff @(posedge clk_i) begin
        if (take) begin
            dir_q  <= head_dir;
            hold_q <= head[`SPI_CMD_HOLD_BIT];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state      <= seq_idle;
            cs_q       <= 1'b1;
            bytes_left <= '0;
        end else begin
            case (state)
                seq_idle: begin
                    if (take) begin
                        cs_q       <= 1'b0;  // low the cycle after pop
                        bytes_left <= head[8:0];
                        state      <= seq_issue;
                    end
                end
                seq_issue: begin
                    if (link.byte_req) begin
                        state <= seq_wait;
                    end
                end
                seq_wait: begin
                    if (link.byte_done) begin
                        if (bytes_left == '0) begin
                            if (!hold_q) begin
                                cs_q <= 1'b1;
                            end
                            state <= seq_idle;
                        end else begin
                            bytes_left <= bytes_left - 1'b1;
                            state      <= seq_issue;
                        end
                    end
                end
                default: state <= seq_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/spi_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_shifter import spi_host_pkg::*; (
    input  wire         clk_i,
    input  wire         rst_i,
    input  wire         cpol_i,
    input  wire         cpha_i,
    input  wire div_t   div_i,
    spi_byte_if.slave   link,
    spi_fifo_if.reader  tx_r,
    spi_fifo_if.writer  rx_w,
    output logic        spi_sck_o,
    output logic        spi_mosi_o,
    input  wire         spi_miso_i
);
    shift_state_e state;
    div_t         hc;         // cycles into half period
    logic [2:0]   bit_cnt;
    xfer_dir_e    dir_q;
    logic         last_q;
    logic         done_q;
    logic         sck_q;
    logic         mosi_q;
    word_t        tx_sr;
    logic [4:0]   tx_bits;    // bits left in tx_sr
    word_t        rx_sr;
    logic [4:0]   rx_cnt;
    logic         start;
    logic         half_end;
    logic         lead_edge;
    logic         trail_edge;
    logic         final_edge;
    logic         tx_shift;
    logic         tx_load;
    logic         next_bit;
    logic         rx_sample;
    logic         rx_word;
    logic         rx_flush;

    assign start      = (state == sh_idle) && link.byte_req;
    assign half_end   = (hc == div_i);
    assign lead_edge  = (state == sh_lead) && half_end;
    assign trail_edge = (state == sh_trail) && half_end;
    assign final_edge = trail_edge && (bit_cnt == 3'd7);

    // mode 0 presents the first bit at byte start, then on trailing edges
    assign tx_shift = start ? (link.byte_dir == dir_tx && !cpha_i)
                            : (dir_q == dir_tx) && (cpha_i ? lead_edge
                                                           : trail_edge && !final_edge);
    assign tx_load  = (tx_bits == '0);
    assign next_bit = tx_load ? (!tx_r.empty && tx_r.rdata[0]) : tx_sr[0];
    assign tx_r.pop = tx_shift && tx_load && !tx_r.empty;

    assign rx_sample  = (dir_q == dir_rx) && (cpha_i ? trail_edge : lead_edge);
    assign rx_word    = rx_sample && (rx_cnt == 5'd31);
    assign rx_flush   = done_q && last_q && (rx_cnt != '0);  // zero-filled partial
    assign rx_w.push  = rx_word || rx_flush;
    assign rx_w.wdata = rx_flush ? rx_sr : {spi_miso_i, rx_sr[30:0]};

    assign link.busy      = (state != sh_idle);
    assign link.byte_done = done_q;
    assign spi_sck_o      = sck_q;
    assign spi_mosi_o     = mosi_q;

    always_ff @(posedge clk_i) begin
        if (start) begin
            dir_q  <= link.byte_dir;
            last_q <= link.last_byte;
        end
        if (tx_shift) begin
            tx_sr <= tx_load ? (tx_r.rdata >> 1) : (tx_sr >> 1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state   <= sh_idle;
            hc      <= '0;
            bit_cnt <= '0;
            done_q  <= 1'b0;
            sck_q   <= 1'b0;
            mosi_q  <= 1'b0;
            tx_bits <= '0;
            rx_cnt  <= '0;
            rx_sr   <= '0;
        end else begin
            done_q <= final_edge;
            if (tx_shift) begin
                mosi_q <= next_bit;
            end else if (start) begin
                mosi_q <= 1'b0;  // rx and dummy keep mosi low
            end
            case (state)
                sh_idle: begin
                    sck_q <= cpol_i;
                    if (start) begin
                        hc      <= '0;
                        bit_cnt <= '0;
                        state   <= sh_lead;
                    end
                end
                sh_lead, sh_trail: begin
                    hc <= half_end ? '0 : hc + 1'b1;
                    if (half_end) begin
                        sck_q <= ~sck_q;
                        if (state == sh_lead) begin
                            state <= sh_trail;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            state   <= final_edge ? sh_idle : sh_lead;
                        end
                    end
                end
                default: state <= sh_idle;
            endcase
            if (done_q && last_q) begin
                tx_bits <= '0;  // drop unsent tx bits
            end else if (tx_shift) begin
                tx_bits <= tx_load ? (tx_r.empty ? 5'd0 : 5'd31) : tx_bits - 1'b1;
            end
            if (rx_flush || rx_word) begin
                rx_cnt <= '0;
                rx_sr  <= '0;
            end else if (rx_sample) begin
                rx_sr[rx_cnt] <= spi_miso_i;
                rx_cnt        <= rx_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/spi_host_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_host_consts.svh"

module spi_host_top import spi_host_pkg::*; (
    input  wire           clk_i,
    input  wire           rst_i,

    input  wire           wb_cyc_i,
    input  wire           wb_stb_i,
    input  wire           wb_we_i,
    input  wire wb_addr_t wb_adr_i,
    input  wire word_t    wb_dat_i,
    output word_t         wb_dat_o,
    output logic          wb_ack_o,

    output logic          spi_cs_o,
    output logic          spi_sck_o,
    output logic          spi_mosi_o,
    input  wire           spi_miso_i
);
    logic cpol;
    logic cpha;
    logic en;
    div_t div;
    logic seq_busy;

    spi_fifo_if #(.WIDTH($bits(cmd_t)))  cmd_q ();
    spi_fifo_if #(.WIDTH($bits(word_t))) tx_q ();
    spi_fifo_if #(.WIDTH($bits(word_t))) rx_q ();
    spi_byte_if                          link ();

    spi_wb_regs u_regs (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .cmd_w      (cmd_q.writer),
        .tx_w       (tx_q.writer),
        .rx_r       (rx_q.reader),
        .seq_busy_i (seq_busy),
        .cpol_o     (cpol),
        .cpha_o     (cpha),
        .en_o       (en),
        .div_o      (div)
    );

    spi_word_fifo #(.WIDTH($bits(cmd_t)), .DEPTH(`SPI_CMD_DEPTH)) u_cmd_q (
        .clk_i (clk_i), .rst_i (rst_i), .wr (cmd_q.sink), .rd (cmd_q.source)
    );
    spi_word_fifo #(.WIDTH($bits(word_t)), .DEPTH(`SPI_DATA_DEPTH)) u_tx_q (
        .clk_i (clk_i), .rst_i (rst_i), .wr (tx_q.sink), .rd (tx_q.source)
    );
    spi_word_fifo #(.WIDTH($bits(word_t)), .DEPTH(`SPI_DATA_DEPTH)) u_rx_q (
        .clk_i (clk_i), .rst_i (rst_i), .wr (rx_q.sink), .rd (rx_q.source)
    );

    spi_sequencer u_seq (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .en_i     (en),
        .cmd_r    (cmd_q.reader),
        .link     (link.master),
        .spi_cs_o (spi_cs_o),
        .busy_o   (seq_busy)
    );

    spi_shifter u_shift (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .cpol_i     (cpol),
        .cpha_i     (cpha),
        .div_i      (div),
        .link       (link.slave),
        .tx_r       (tx_q.reader),
        .rx_w       (rx_q.writer),
        .spi_sck_o  (spi_sck_o),
        .spi_mosi_o (spi_mosi_o),
        .spi_miso_i (spi_miso_i)
    );

endmodule

`default_nettype wire

// ==== verif/spi_host_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_host_checker (
    input  wire  clk_i,
    input  wire  rst_i,
    input  wire  spi_cs_i,
    input  wire  spi_sck_i,
    input  wire  spi_mosi_i
);
    int   mismatches = 0;
    int   failures = 0;
    int   lead_edges = 0;
    int   edge_in_byte = 0;
    int   gap = 0;
    int   div = 0;
    logic cpol = 1'b0;
    logic cpha = 1'b0;
    logic sck_prev;
    logic exp_mosi[$];  // bits expected on sampling edges

    task automatic set_mode(input logic pol, input logic pha, input int d);
        cpol         = pol;
        cpha         = pha;
        div          = d;
        lead_edges   = 0;
        edge_in_byte = 0;
        exp_mosi     = {};
    endtask

    task automatic expect_mosi(input logic b);
        exp_mosi.push_back(b);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t ns: %s expected 0x%08h, got 0x%08h",
                     $time, name, exp, act);
        end
    endtask

    task automatic report_error(input string msg);
        failures++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    // pins are stable mid-cycle
    always @(negedge clk_i) begin
        logic leading;
        if (rst_i) begin
            sck_prev = spi_sck_i;
            gap      = 0;
        end else begin
            gap++;
            if (spi_sck_i !== sck_prev && !spi_cs_i) begin
                leading = (spi_sck_i != cpol);
                if (leading) begin
                    lead_edges++;
                end
                if (edge_in_byte != 0) begin
                    check_value("SCK half period", div + 1, gap);  // gaps between bytes vary
                end
                edge_in_byte = (edge_in_byte + 1) % 16;
                if (leading != cpha) begin
                    if (exp_mosi.size() == 0) begin
                        report_error("MOSI sampled with no expected bit left");
                    end else begin
                        check_value("spi_mosi_o", exp_mosi.pop_front(), spi_mosi_i);
                    end
                end
            end
            if (spi_sck_i !== sck_prev) begin
                gap = 0;
            end
            sck_prev = spi_sck_i;
        end
    end

endmodule

`default_nettype wire

// ==== verif/spi_host_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_host_consts.svh"

module spi_host_tb import spi_host_pkg::*; ();
    typedef struct packed {
        logic        cpol;
        logic        cpha;
        logic [15:0] div;
        logic [1:0]  dir;
        logic [8:0]  len;
        logic        hold;
        logic        en_late;  // enable only after checking the idle state
        logic [3:0]  ntx;
        logic [2:0]  nreads;
    } entry_t;

    logic     clk_i = 1'b0;
    logic     rst_i;
    logic     wb_cyc_i;
    logic     wb_stb_i;
    logic     wb_we_i;
    wb_addr_t wb_adr_i;
    word_t    wb_dat_i;
    word_t    wb_dat_o;
    logic     wb_ack_o;
    logic     spi_cs_o;
    logic     spi_sck_o;
    logic     spi_mosi_o;
    logic     spi_miso_i;

    logic [31:0] rng = 32'd12;
    entry_t      table_q[$];
    logic        rx_bits[$];  // miso stream as driven
    int          cycles = 0;
    int          limit = 0;
    logic        rx_drive;
    logic        cur_cpol;
    logic        cur_cpha;
    logic        sck_last;

    spi_host_top u_dut (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .spi_cs_o   (spi_cs_o),
        .spi_sck_o  (spi_sck_o),
        .spi_mosi_o (spi_mosi_o),
        .spi_miso_i (spi_miso_i)
    );

    spi_host_checker u_chk (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .spi_cs_i   (spi_cs_o),
        .spi_sck_i  (spi_sck_o),
        .spi_mosi_i (spi_mosi_o)
    );

    always #4 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t ctrl_word(input entry_t e, input logic en);
        return (word_t'(e.div) << `SPI_CTRL_DIV_LSB) | (word_t'(e.cpol) << `SPI_CTRL_CPOL_BIT)
             | (word_t'(e.cpha) << `SPI_CTRL_CPHA_BIT) | (word_t'(en) << `SPI_CTRL_EN_BIT);
    endfunction

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run passed %0d cycles, %0d mismatches, %0d other failures",
                     limit, u_chk.mismatches, u_chk.failures);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic drive_miso_bit();
        rng        = xorshift(rng);
        spi_miso_i = rng[0];
        rx_bits.push_back(rng[0]);
    endtask

    // miso moves on the edge the DUT does not sample on
    always @(posedge clk_i) begin
        #1;
        if (rx_drive && !spi_cs_o && spi_sck_o !== sck_last
                && ((spi_sck_o != cur_cpol) == cur_cpha)) begin
            drive_miso_bit();
        end
        sck_last = spi_sck_o;
    end

    // called and returns 1 ns after a rising edge
    task automatic wb_access(input logic we, input wb_addr_t adr, input word_t wdata,
                             output word_t rdata);
        int waited;
        waited   = 0;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdata;
        @(posedge clk_i);
        #1;
        while (!wb_ack_o && waited < 8) begin
            @(posedge clk_i);
            #1;
            waited++;
        end
        if (waited != 0) begin
            u_chk.report_error($sformatf("ack at 0x%02h came %0d cycles late", adr, waited));
        end
        rdata    = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        @(posedge clk_i);
        #1;
        if (wb_ack_o) begin
            u_chk.report_error("ack stayed high for more than one cycle");
        end
    endtask

    task automatic wb_write(input wb_addr_t adr, input word_t data);
        word_t unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read_check(input wb_addr_t adr, input word_t exp, input string name);
        word_t got;
        wb_access(1'b0, adr, '0, got);
        u_chk.check_value(name, exp, got);
    endtask

    task automatic wait_idle();
        word_t st;
        do begin
            wb_access(1'b0, `SPI_ADDR_STATUS, '0, st);
        end while (st[6] || !st[5]);  // busy, or cmd_q not yet empty
    endtask

    task automatic run_entry(input entry_t e);
        int    nbits;
        int    i;
        word_t words[$];
        word_t st;
        word_t exp;
        nbits = 8 * (e.len + 1);
        u_chk.set_mode(e.cpol, e.cpha, e.div);
        cur_cpol = e.cpol;
        cur_cpha = e.cpha;
        wb_write(`SPI_ADDR_CTRL, ctrl_word(e, 1'b0));
        for (i = 0; i < e.ntx; i++) begin
            rng = xorshift(rng);
            words.push_back(rng);
            wb_write(`SPI_ADDR_WDATA, rng);
        end
        if (e.ntx > `SPI_DATA_DEPTH) begin
            wb_access(1'b0, `SPI_ADDR_STATUS, '0, st);
            u_chk.check_value("STATUS tx full", 1, st[0]);
        end
        for (i = 0; i < nbits; i++) begin
            // only the first DEPTH words fit, missing data goes out as zeros
            if (e.dir == dir_tx && i / 32 < words.size() && i / 32 < `SPI_DATA_DEPTH) begin
                u_chk.expect_mosi(words[i / 32][i % 32]);
            end else begin
                u_chk.expect_mosi(1'b0);
            end
        end
        rx_bits  = {};
        rx_drive = (e.dir == dir_rx);
        if (rx_drive && !e.cpha) begin
            drive_miso_bit();  // first bit ahead of the first leading edge
        end
        wb_write(`SPI_ADDR_CMD, (word_t'(e.dir) << `SPI_CMD_DIR_LSB)
                 | (word_t'(e.hold) << `SPI_CMD_HOLD_BIT) | word_t'(e.len));
        if (e.en_late) begin
            repeat (20) @(posedge clk_i);
            #1;
            u_chk.check_value("spi_cs_o while disabled", 1, spi_cs_o);
            wb_access(1'b0, `SPI_ADDR_STATUS, '0, st);
            u_chk.check_value("STATUS cmd empty while disabled", 0, st[5]);
        end
        wb_write(`SPI_ADDR_CTRL, ctrl_word(e, 1'b1));
        wait_idle();
        rx_drive = 1'b0;
        u_chk.check_value("leading SCK edges", nbits, u_chk.lead_edges);
        u_chk.check_value("MOSI bits not seen", 0, u_chk.exp_mosi.size());
        u_chk.check_value("spi_cs_o after command", !e.hold, spi_cs_o);
        u_chk.check_value("spi_sck_o at rest", e.cpol, spi_sck_o);
        for (i = 0; i < e.nreads; i++) begin
            exp = '0;
            for (int j = 0; j < 32; j++) begin
                if (e.dir == dir_rx && 32 * i + j < nbits) begin
                    exp[j] = rx_bits[32 * i + j];
                end
            end
            wb_read_check(`SPI_ADDR_RDATA, exp, "RDATA");
        end
    endtask

    initial begin
        wb_cyc_i   = 1'b0;
        wb_stb_i   = 1'b0;
        wb_we_i    = 1'b0;
        wb_adr_i   = '0;
        wb_dat_i   = '0;
        spi_miso_i = 1'b0;
        rst_i      = 1'b1;
        rx_drive   = 1'b0;
        cur_cpol   = 1'b0;
        cur_cpha   = 1'b0;
        sck_last   = 1'b0;

        // cpol cpha div dir len hold en_late ntx nreads
        table_q.push_back(entry_t'{1'b0, 1'b0, 16'd1, dir_tx, 9'd3, 1'b0, 1'b0, 4'd1, 3'd0});
        table_q.push_back(entry_t'{1'b0, 1'b1, 16'd0, dir_tx, 9'd5, 1'b0, 1'b0, 4'd2, 3'd0});
        table_q.push_back(entry_t'{1'b1, 1'b0, 16'd2, dir_tx, 9'd1, 1'b0, 1'b0, 4'd1, 3'd0});
        table_q.push_back(entry_t'{1'b1, 1'b1, 16'd1, dir_tx, 9'd2, 1'b0, 1'b0, 4'd1, 3'd0});
        table_q.push_back(entry_t'{1'b0, 1'b0, 16'd1, dir_rx, 9'd4, 1'b0, 1'b0, 4'd0, 3'd3});
        table_q.push_back(entry_t'{1'b1, 1'b1, 16'd0, dir_rx, 9'd2, 1'b0, 1'b0, 4'd0, 3'd2});
        table_q.push_back(entry_t'{1'b0, 1'b1, 16'd1, dir_dummy, 9'd2, 1'b0, 1'b0, 4'd0, 3'd1});
        table_q.push_back(entry_t'{1'b0, 1'b0, 16'd0, dir_tx, 9'd0, 1'b1, 1'b0, 4'd1, 3'd0});
        table_q.push_back(entry_t'{1'b0, 1'b0, 16'd0, dir_rx, 9'd0, 1'b0, 1'b0, 4'd0, 3'd2});
        table_q.push_back(entry_t'{1'b0, 1'b0, 16'd1, dir_tx, 9'd0, 1'b0, 1'b1, 4'd1, 3'd0});
        table_q.push_back(entry_t'{1'b0, 1'b0, 16'd0, dir_tx, 9'd35, 1'b0, 1'b0, 4'd9, 3'd0});
        foreach (table_q[k]) begin
            limit += 2 * 16 * (table_q[k].div + 1) * (table_q[k].len + 1) + 200;
        end

        repeat (16) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        u_chk.check_value("spi_cs_o after reset", 1, spi_cs_o);
        u_chk.check_value("spi_sck_o after reset", 0, spi_sck_o);
        u_chk.check_value("spi_mosi_o after reset", 0, spi_mosi_o);
        u_chk.check_value("wb_ack_o after reset", 0, wb_ack_o);
        wb_read_check(`SPI_ADDR_STATUS, 32'h0000_002a, "STATUS after reset");
        wb_read_check(`SPI_ADDR_RDATA, 32'h0, "RDATA after reset");

        foreach (table_q[k]) begin
            run_entry(table_q[k]);
        end

        $display("errors: %0d mismatches, %0d other failures",
                 u_chk.mismatches, u_chk.failures);
        if (u_chk.mismatches + u_chk.failures == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== spi_host_top.f ====
+incdir+include
design/spi_host_pkg.sv
design/spi_fifo_if.sv
design/spi_word_fifo.sv
design/spi_wb_regs.sv
design/spi_sequencer.sv
design/spi_shifter.sv
design/spi_host_top.sv
verif/spi_host_checker.sv
verif/spi_host_tb.sv
